// File: Makefile
VERILATOR ?= verilator
TB_TOP ?= rv_execute_tb
RTL_TOP ?= rv_execute_top
FILELIST ?= rv_execute.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data word width.
`define RV_XLEN 32

// Register index width.
`define RV_REG_ADDR_W 5

// Wishbone byte address width.
`define RV_WB_ADDR_W 32

// One quotient bit per divider iteration.
`define RV_DIV_STEPS 32

`endif

// File: common/rv_exec_pkg.sv
`include "rv_defs.svh"

package rv_exec_pkg;

	// Decoded instruction as presented by the issuer.
	typedef struct packed {
		logic valid;
		rv_isa_pkg::word_t pc;
		rv_isa_pkg::word_t rs1;
		rv_isa_pkg::word_t rs2;
		rv_isa_pkg::word_t imm;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::inst_class_t inst_class;
		rv_isa_pkg::alu_op_t alu_op;
		rv_isa_pkg::operand_sel_t operand1_sel;
		rv_isa_pkg::operand_sel_t operand2_sel;
		rv_isa_pkg::mem_width_t mem_width;
		logic mem_signed;
		rv_isa_pkg::cplx_op_t cplx_op;
	} issue_t;

	typedef struct packed {
		logic valid;
		rv_isa_pkg::reg_addr_t rd;
		logic write_en;
		rv_isa_pkg::word_t value;
		rv_isa_pkg::word_t pc_next;
	} result_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`RV_WB_ADDR_W-1:0] adr;
		rv_isa_pkg::word_t dat_o;
		logic [3:0] sel;
	} wb_req_t;

	// Held by the controller until the load/store unit reports done.
	typedef struct packed {
		logic valid;
		logic write;
		rv_isa_pkg::word_t address;
		rv_isa_pkg::word_t data;
		rv_isa_pkg::mem_width_t width;
		logic is_signed;
	} mem_req_t;

endpackage

// File: common/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [2*`RV_XLEN-1:0] dword_t;
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
		ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
		ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic [2:0] {
		OPSEL_ZERO, OPSEL_RS1, OPSEL_RS2, OPSEL_PC, OPSEL_IMM
	} operand_sel_t;

	typedef enum logic [1:0] {
		MEM_BYTE, MEM_HALF, MEM_WORD
	} mem_width_t;

	// Divide group has bit 2 set.
	typedef enum logic [2:0] {
		CPLX_MUL, CPLX_MULH, CPLX_MULHSU, CPLX_MULHU,
		CPLX_DIV, CPLX_DIVU, CPLX_REM, CPLX_REMU
	} cplx_op_t;

	typedef enum logic [2:0] {
		CLASS_ARITH, CLASS_COMPARE, CLASS_JUMP, CLASS_BRANCH,
		CLASS_LOAD, CLASS_STORE, CLASS_COMPLEX
	} inst_class_t;

endpackage

// File: execute/rv_divide.sv
`include "rv_defs.svh"
`timescale 1ns/1ps

module rv_divide (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input logic i_signed,
	input rv_isa_pkg::word_t i_dividend,
	input rv_isa_pkg::word_t i_divisor,
	output logic o_done,
	output rv_isa_pkg::word_t o_quotient,
	output rv_isa_pkg::word_t o_remainder
);

	import rv_isa_pkg::*;

	localparam int W = `RV_XLEN;
	localparam int STEPS = `RV_DIV_STEPS;
	localparam int CNT_W = $clog2(STEPS);

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FINISH
	} div_state_t;

	div_state_t state;
	logic [CNT_W-1:0] count;
	word_t quo_q;
	word_t rem_q;
	word_t divisor_q;
	logic neg_quo;
	logic neg_rem;
	logic dividend_neg;
	logic divisor_neg;
	logic [W:0] partial;
	logic [W:0] diff;

	assign dividend_neg = i_signed & i_dividend[W-1];
	assign divisor_neg = i_signed & i_divisor[W-1];

	assign partial = {rem_q, quo_q[W-1]};
	assign diff = partial - {1'b0, divisor_q};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= DIV_IDLE;
		end else begin
			case (state)
				DIV_IDLE: if (i_start) state <= DIV_RUN;
				DIV_RUN: if (count == CNT_W'(STEPS - 1)) state <= DIV_FINISH;
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == DIV_IDLE) begin
			count <= '0;
			rem_q <= '0;
			quo_q <= dividend_neg ? -i_dividend : i_dividend;
			divisor_q <= divisor_neg ? -i_divisor : i_divisor;
			// Zero divisor keeps all ones in the quotient.
			neg_quo <= (dividend_neg ^ divisor_neg) && (i_divisor != '0);
			neg_rem <= dividend_neg;
		end else if (state == DIV_RUN) begin
			count <= count + 1'b1;
			if (!diff[W]) begin
				rem_q <= diff[W-1:0];
				quo_q <= {quo_q[W-2:0], 1'b1};
			end else begin
				rem_q <= partial[W-1:0];
				quo_q <= {quo_q[W-2:0], 1'b0};
			end
		end
	end

	// Most negative over minus one falls out as the dividend with remainder zero.
	assign o_done = state == DIV_FINISH;
	assign o_quotient = neg_quo ? -quo_q : quo_q;
	assign o_remainder = neg_rem ? -rem_q : rem_q;

endmodule

// File: execute/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input logic i_clock,
	input logic i_reset,
	input rv_exec_pkg::issue_t i_issue,
	output logic o_stall,
	output rv_exec_pkg::result_t o_result,
	output rv_exec_pkg::mem_req_t o_mem_req,
	input logic i_mem_done,
	input rv_isa_pkg::word_t i_mem_data
);

	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	localparam int MUL_LATENCY = 2;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_WAIT,
		ST_DIV_WAIT,
		ST_MEM_WAIT
	} exec_state_t;

	exec_state_t state;
	issue_t iss_q;
	issue_t cur;
	logic accept;
	logic [$clog2(MUL_LATENCY)-1:0] mul_cnt;
	word_t operand1;
	word_t operand2;
	word_t alu_result;
	logic alu_compare;
	word_t pc_plus4;
	word_t branch_target;
	logic is_div;
	dword_t product;
	logic div_done;
	word_t quotient;
	word_t remainder;
	word_t cplx_value;

	function automatic word_t select_operand(operand_sel_t sel, issue_t iss);
		case (sel)
			OPSEL_RS1: return iss.rs1;
			OPSEL_RS2: return iss.rs2;
			OPSEL_PC: return iss.pc;
			OPSEL_IMM: return iss.imm;
			default: return '0;
		endcase
	endfunction

	// Issue fields only hold in the accepting cycle.
	assign cur = (state == ST_IDLE) ? i_issue : iss_q;
	assign accept = i_issue.valid && !o_stall;

	assign operand1 = select_operand(cur.operand1_sel, cur);
	assign operand2 = select_operand(cur.operand2_sel, cur);
	assign pc_plus4 = cur.pc + word_t'(4);
	assign branch_target = cur.pc + cur.imm;
	assign is_div = cur.cplx_op[2];

	rv_alu alu (
		.i_op(cur.alu_op),
		.i_operand1(operand1),
		.i_operand2(operand2),
		.o_result(alu_result),
		.o_compare(alu_compare)
	);

	rv_multiply multiply (
		.i_clock(i_clock),
		.i_op1_signed(cur.cplx_op != CPLX_MULHU),
		.i_op2_signed(cur.cplx_op inside {CPLX_MUL, CPLX_MULH}),
		.i_op1(cur.rs1),
		.i_op2(cur.rs2),
		.o_product(product)
	);

	rv_divide divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(accept && (cur.inst_class == CLASS_COMPLEX) && is_div),
		.i_signed(cur.cplx_op inside {CPLX_DIV, CPLX_REM}),
		.i_dividend(cur.rs1),
		.i_divisor(cur.rs2),
		.o_done(div_done),
		.o_quotient(quotient),
		.o_remainder(remainder)
	);

	always_comb begin
		case (iss_q.cplx_op)
			CPLX_MUL: cplx_value = product[$bits(word_t)-1:0];
			CPLX_MULH, CPLX_MULHSU, CPLX_MULHU: cplx_value = product[$bits(dword_t)-1:$bits(word_t)];
			CPLX_DIV, CPLX_DIVU: cplx_value = quotient;
			default: cplx_value = remainder;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_stall <= 1'b0;
			o_result.valid <= 1'b0;
			o_mem_req.valid <= 1'b0;
			mul_cnt <= '0;
		end else begin
			o_result.valid <= 1'b0;
			case (state)
				ST_IDLE: if (accept) begin
					iss_q <= i_issue;
					o_result.rd <= cur.rd;
					o_result.write_en <= 1'b1;
					o_result.value <= alu_result;
					o_result.pc_next <= pc_plus4;
					case (cur.inst_class)
						CLASS_ARITH: o_result.valid <= 1'b1;
						CLASS_COMPARE: begin
							o_result.value <= word_t'(alu_compare);
							o_result.valid <= 1'b1;
						end
						CLASS_JUMP: begin
							o_result.value <= pc_plus4;
							o_result.pc_next <= alu_result;
							o_result.valid <= 1'b1;
						end
						CLASS_BRANCH: begin
							o_result.write_en <= 1'b0;
							if (alu_compare) o_result.pc_next <= branch_target;
							o_result.valid <= 1'b1;
						end
						CLASS_LOAD, CLASS_STORE: begin
							o_result.write_en <= cur.inst_class == CLASS_LOAD;
							o_mem_req.valid <= 1'b1;
							o_mem_req.write <= cur.inst_class == CLASS_STORE;
							o_mem_req.address <= alu_result;
							o_mem_req.data <= cur.rs2;
							o_mem_req.width <= cur.mem_width;
							o_mem_req.is_signed <= cur.mem_signed;
							o_stall <= 1'b1;
							state <= ST_MEM_WAIT;
						end
						default: begin
							o_stall <= 1'b1;
							mul_cnt <= '0;
							state <= is_div ? ST_DIV_WAIT : ST_MUL_WAIT;
						end
					endcase
				end
				ST_MUL_WAIT: begin
					mul_cnt <= mul_cnt + 1'b1;
					if (mul_cnt == $bits(mul_cnt)'(MUL_LATENCY - 1)) begin
						o_result.value <= cplx_value;
						o_result.valid <= 1'b1;
						o_stall <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_DIV_WAIT: if (div_done) begin
					o_result.value <= cplx_value;
					o_result.valid <= 1'b1;
					o_stall <= 1'b0;
					state <= ST_IDLE;
				end
				default: if (i_mem_done) begin
					o_mem_req.valid <= 1'b0;
					o_result.value <= i_mem_data;
					o_result.valid <= 1'b1;
					o_stall <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: execute/rv_multiply.sv
`timescale 1ns/1ps

module rv_multiply (
	input logic i_clock,
	input logic i_op1_signed,
	input logic i_op2_signed,
	input rv_isa_pkg::word_t i_op1,
	input rv_isa_pkg::word_t i_op2,
	output rv_isa_pkg::dword_t o_product
);

	import rv_isa_pkg::*;

	localparam int W = $bits(word_t);

	logic signed [W:0] op1_q;
	logic signed [W:0] op2_q;
	logic signed [2*W+1:0] full_product;

	// Stage 1. The extra bit lets one signed multiply cover every sign mix.
	always_ff @(posedge i_clock) begin
		op1_q <= {i_op1_signed & i_op1[W-1], i_op1};
		op2_q <= {i_op2_signed & i_op2[W-1], i_op2};
	end

	assign full_product = op1_q * op2_q;

	// Stage 2.
	always_ff @(posedge i_clock) begin
		o_product <= full_product[2*W-1:0];
	end

endmodule

// File: rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input rv_isa_pkg::alu_op_t i_op,
	input rv_isa_pkg::word_t i_operand1,
	input rv_isa_pkg::word_t i_operand2,
	output rv_isa_pkg::word_t o_result,
	output logic o_compare
);

	import rv_isa_pkg::*;

	logic [4:0] shamt;
	logic is_lt;
	logic is_ltu;

	assign shamt = i_operand2[4:0];
	assign is_lt = $signed(i_operand1) < $signed(i_operand2);
	assign is_ltu = i_operand1 < i_operand2;

	always_comb begin
		case (i_op)
			ALU_EQ: o_compare = i_operand1 == i_operand2;
			ALU_NE: o_compare = i_operand1 != i_operand2;
			ALU_LT, ALU_SLT: o_compare = is_lt;
			ALU_GE: o_compare = !is_lt;
			ALU_LTU, ALU_SLTU: o_compare = is_ltu;
			ALU_GEU: o_compare = !is_ltu;
			default: o_compare = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_operand1 + i_operand2;
			ALU_SUB: o_result = i_operand1 - i_operand2;
			ALU_SLL: o_result = i_operand1 << shamt;
			ALU_XOR: o_result = i_operand1 ^ i_operand2;
			ALU_SRL: o_result = i_operand1 >> shamt;
			ALU_SRA: o_result = word_t'($signed(i_operand1) >>> shamt);
			ALU_OR: o_result = i_operand1 | i_operand2;
			ALU_AND: o_result = i_operand1 & i_operand2;
			// Set and compare operations yield 0 or 1.
			default: o_result = word_t'(o_compare);
		endcase
	end

endmodule

// File: rtl/rv_execute_top.sv
`timescale 1ns/1ps

module rv_execute_top (
	input logic i_clock,
	input logic i_reset,
	input rv_exec_pkg::issue_t i_issue,
	output logic o_stall,
	output rv_exec_pkg::result_t o_result,
	output rv_exec_pkg::wb_req_t o_wb,
	input logic i_wb_ack,
	input rv_isa_pkg::word_t i_wb_dat
);

	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	mem_req_t mem_req;
	logic mem_done;
	word_t mem_data;

	rv_execute execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_issue(i_issue),
		.o_stall(o_stall),
		.o_result(o_result),
		.o_mem_req(mem_req),
		.i_mem_done(mem_done),
		.i_mem_data(mem_data)
	);

	rv_lsu_wishbone lsu (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_mem_req(mem_req),
		.o_mem_done(mem_done),
		.o_mem_data(mem_data),
		.o_wb(o_wb),
		.i_wb_ack(i_wb_ack),
		.i_wb_dat(i_wb_dat)
	);

endmodule

// File: rtl/rv_lsu_wishbone.sv
`include "rv_defs.svh"
`timescale 1ns/1ps

module rv_lsu_wishbone (
	input logic i_clock,
	input logic i_reset,
	input rv_exec_pkg::mem_req_t i_mem_req,
	output logic o_mem_done,
	output rv_isa_pkg::word_t o_mem_data,
	output rv_exec_pkg::wb_req_t o_wb,
	input logic i_wb_ack,
	input rv_isa_pkg::word_t i_wb_dat
);

	import rv_isa_pkg::*;

	localparam int W = `RV_XLEN;

	logic [1:0] byte_off;
	logic [4:0] lane_shift;
	logic [3:0] lane_sel;
	word_t load_word;

	always_comb begin
		case (i_mem_req.width)
			MEM_BYTE: begin
				byte_off = i_mem_req.address[1:0];
				lane_sel = 4'b0001 << byte_off;
			end
			MEM_HALF: begin
				byte_off = {i_mem_req.address[1], 1'b0};
				lane_sel = 4'b0011 << byte_off;
			end
			default: begin
				byte_off = 2'b00;
				lane_sel = 4'b1111;
			end
		endcase
	end

	assign lane_shift = {byte_off, 3'b000};

	// One classic cycle per request, ended by ack.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb.cyc <= 1'b0;
			o_wb.stb <= 1'b0;
		end else if (o_wb.cyc) begin
			if (i_wb_ack) begin
				o_wb.cyc <= 1'b0;
				o_wb.stb <= 1'b0;
			end
		end else if (i_mem_req.valid) begin
			o_wb.cyc <= 1'b1;
			o_wb.stb <= 1'b1;
			o_wb.we <= i_mem_req.write;
			o_wb.adr <= {i_mem_req.address[`RV_WB_ADDR_W-1:2], 2'b00};
			o_wb.sel <= lane_sel;
			o_wb.dat_o <= i_mem_req.data << lane_shift;
		end
	end

	assign o_mem_done = o_wb.cyc && i_wb_ack;
	assign load_word = i_wb_dat >> lane_shift;

	always_comb begin
		case (i_mem_req.width)
			MEM_BYTE: o_mem_data = {{(W-8){i_mem_req.is_signed & load_word[7]}}, load_word[7:0]};
			MEM_HALF: o_mem_data = {{(W-16){i_mem_req.is_signed & load_word[15]}}, load_word[15:0]};
			default: o_mem_data = load_word;
		endcase
	end

endmodule

// File: rv_execute.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_exec_pkg.sv
rtl/rv_alu.sv
execute/rv_multiply.sv
execute/rv_divide.sv
execute/rv_execute.sv
rtl/rv_lsu_wishbone.sv
rtl/rv_execute_top.sv
verification/rv_execute_tb.sv

// File: verification/rv_execute_tb.sv
`include "rv_defs.svh"
`timescale 1ns/1ps

module rv_execute_tb;

	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int N_ALU = 40;
	localparam int N_JUMP_BRANCH = 24;
	localparam int N_MUL = 40;
	localparam int N_DIV = 32;
	localparam int N_MEM = 32;
	localparam int TEST_COUNT = N_ALU + N_JUMP_BRANCH + N_MUL + N_DIV + N_MEM;
	localparam int MAX_LATENCY = `RV_DIV_STEPS + 2;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * (MAX_LATENCY + 12) + 50;
	localparam word_t CORNERS [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

	logic clock = 1'b0;
	logic reset = 1'b1;
	issue_t issue = '0;
	logic stall;
	result_t result;
	wb_req_t wb;
	logic wb_ack = 1'b0;
	word_t wb_dat = '0;

	word_t mem [0:255];
	word_t shadow [0:255];
	logic [1:0] wait_left = '0;
	logic [`RV_WB_ADDR_W-1:0] seen_adr = '0;
	logic [3:0] seen_sel = '0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	wb_req_t prev_wb = '0;
	logic prev_ack = 1'b0;

	rv_execute_top u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_issue(issue),
		.o_stall(stall),
		.o_result(result),
		.o_wb(wb),
		.i_wb_ack(wb_ack),
		.i_wb_dat(wb_dat)
	);

	initial begin
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check(input bit ok, input bit is_value, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			if (is_value)
				$display("Error %0t: %s", $time, msg);
			else
				$display("%s (at %0t)", msg, $time);
		end
	endtask

	function automatic word_t fill_word(int i);
		return (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ (word_t'(i) << 24);
	endfunction

	////////////////////////////////////////////////////////////
	// Wishbone memory with random wait states
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
			wait_left <= '0;
			for (int i = 0; i < 256; i++)
				mem[i] <= fill_word(i);
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb.cyc && wb.stb) begin
			if (wait_left == 0) begin
				wb_ack <= 1'b1;
				wb_dat <= mem[wb.adr[9:2]];
				seen_adr <= wb.adr;
				seen_sel <= wb.sel;
				if (wb.we) begin
					for (int i = 0; i < 4; i++)
						if (wb.sel[i])
							mem[wb.adr[9:2]][8*i +: 8] <= wb.dat_o[8*i +: 8];
				end
			end else begin
				wait_left <= wait_left - 1'b1;
			end
		end else begin
			wait_left <= 2'($urandom % 4);
		end
	end

	// Classic cycle rules hold on every edge.
	always @(posedge clock) begin
		if (!reset) begin
			if (wb.cyc || wb.stb)
				check(wb.cyc == wb.stb, 0, "Wishbone cyc and stb are not equal");
			if (prev_wb.cyc && !prev_ack) begin
				check(wb.cyc, 0, "Wishbone cycle ended without an ack");
				check(wb.we == prev_wb.we && wb.adr == prev_wb.adr && wb.sel == prev_wb.sel
					&& wb.dat_o == prev_wb.dat_o, 0, "Wishbone request changed before ack");
			end
			if (prev_wb.cyc && prev_ack)
				check(!wb.cyc, 0, "Wishbone cycle stayed open after ack");
		end
		prev_wb = wb;
		prev_ack = wb_ack;
	end

	// The memory model records the request it acked last.
	task automatic check_bus_request(input word_t addr, input logic [3:0] lanes);
		check(seen_adr == {addr[31:2], 2'b00} && seen_sel == lanes, 1,
			$sformatf("Wishbone adr %h sel %b, expected %h %b", seen_adr, seen_sel,
			{addr[31:2], 2'b00}, lanes));
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic word_t pick_operand(operand_sel_t sel, issue_t iss);
		case (sel)
			OPSEL_RS1: return iss.rs1;
			OPSEL_RS2: return iss.rs2;
			OPSEL_PC: return iss.pc;
			OPSEL_IMM: return iss.imm;
			default: return '0;
		endcase
	endfunction

	function automatic bit compare_ref(alu_op_t op, word_t a, word_t b);
		case (op)
			ALU_EQ: return a == b;
			ALU_NE: return a != b;
			ALU_LT, ALU_SLT: return $signed(a) < $signed(b);
			ALU_GE: return $signed(a) >= $signed(b);
			ALU_LTU, ALU_SLTU: return a < b;
			ALU_GEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_SLL: return a << b[4:0];
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			default: return word_t'(compare_ref(op, a, b));
		endcase
	endfunction

	function automatic word_t mul_ref(cplx_op_t op, word_t a, word_t b);
		dword_t p;
		case (op)
			CPLX_MULHU: p = {32'b0, a} * {32'b0, b};
			CPLX_MULHSU: p = dword_t'(longint'($signed(a)) * longint'({32'b0, b}));
			default: p = dword_t'(longint'($signed(a)) * longint'($signed(b)));
		endcase
		return (op == CPLX_MUL) ? p[31:0] : p[63:32];
	endfunction

	function automatic word_t div_ref(cplx_op_t op, word_t a, word_t b);
		bit sgn;
		word_t q;
		word_t r;
		sgn = (op == CPLX_DIV) || (op == CPLX_REM);
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (sgn && a == 32'h8000_0000 && b == '1) begin
			q = a;
			r = '0;
		end else if (sgn) begin
			q = word_t'($signed(a) / $signed(b));
			r = word_t'($signed(a) % $signed(b));
		end else begin
			q = a / b;
			r = a % b;
		end
		return (op == CPLX_DIV || op == CPLX_DIVU) ? q : r;
	endfunction

	function automatic word_t load_ref(word_t addr, mem_width_t width, bit sgn);
		word_t w;
		w = shadow[addr[9:2]];
		case (width)
			MEM_BYTE: return {{24{sgn & w[8*addr[1:0] + 7]}}, w[8*addr[1:0] +: 8]};
			MEM_HALF: return {{16{sgn & w[16*addr[1] + 15]}}, w[16*addr[1] +: 16]};
			default: return w;
		endcase
	endfunction

	function automatic issue_t new_issue(inst_class_t cls);
		issue_t iss;
		iss = '0;
		iss.valid = 1'b1;
		iss.pc = {30'($urandom), 2'b00};
		iss.rs1 = $urandom;
		iss.rs2 = $urandom;
		iss.imm = $urandom;
		iss.rd = reg_addr_t'($urandom);
		iss.inst_class = cls;
		iss.alu_op = ALU_ADD;
		iss.operand1_sel = OPSEL_RS1;
		iss.operand2_sel = OPSEL_IMM;
		iss.mem_width = MEM_WORD;
		return iss;
	endfunction

	function automatic result_t expected(issue_t iss, bit we, word_t value, word_t pc_next);
		result_t r;
		r.valid = 1'b1;
		r.rd = iss.rd;
		r.write_en = we;
		r.value = value;
		r.pc_next = pc_next;
		return r;
	endfunction

	// Latency zero stands for memory timing where the result follows the ack.
	task automatic execute_one(input issue_t iss, input result_t exp, input int latency,
		input bit check_value);
		int k;
		bit seen;
		logic last_ack;
		k = 0;
		seen = 0;
		last_ack = 1'b0;
		@(posedge clock);
		issue <= iss;
		@(posedge clock);
		check(!stall, 0, "Stall was high when the request was presented");
		issue.valid <= 1'b0;
		while (!seen) begin
			@(posedge clock);
			k++;
			if (result.valid) begin
				seen = 1;
				if (latency > 0)
					check(k == latency, 0, $sformatf("Result came after %0d cycles, not %0d", k,
						latency));
				else
					check(last_ack, 0, "Load or store result did not follow the ack");
				check(!stall, 0, "Stall still high when the result came");
				check(result.rd == exp.rd, 1, $sformatf("rd %0d, expected %0d",
					result.rd, exp.rd));
				check(result.write_en == exp.write_en, 1, "write_en differs");
				if (check_value)
					check(result.value == exp.value, 1, $sformatf("value %h, expected %h",
						result.value, exp.value));
				check(result.pc_next == exp.pc_next, 1, $sformatf("pc_next %h, expected %h",
					result.pc_next, exp.pc_next));
			end else begin
				check(stall, 0, "Stall dropped before the result");
				last_ack = wb_ack;
			end
		end
	endtask

	task automatic report_group(input string name, input int c0, input int e0);
		$display("Test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	initial begin
		issue_t iss;
		result_t exp;
		int c0;
		int e0;
		int idx;
		int off;
		word_t a;
		word_t b;
		mem_width_t width;
		logic [3:0] lanes;
		void'($urandom(57478));

		c0 = checks;
		e0 = errors;
		for (int i = 0; i < 7; i++) begin
			@(posedge clock);
			if (i == 4)
				reset <= 1'b0;
			if (i > 0)
				check(!result.valid && !stall && !wb.cyc && !wb.stb, 0,
					"Outputs not idle during or after reset");
		end
		for (int i = 0; i < 256; i++)
			shadow[i] = fill_word(i);
		report_group("reset", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int i = 0; i < N_ALU; i++) begin
			iss = new_issue(($urandom % 2) ? CLASS_ARITH : CLASS_COMPARE);
			iss.operand1_sel = operand_sel_t'($urandom % 5);
			iss.operand2_sel = operand_sel_t'($urandom % 5);
			if (iss.inst_class == CLASS_ARITH)
				iss.alu_op = alu_op_t'($urandom % 16);
			else if ($urandom % 4 == 0)
				iss.alu_op = alu_op_t'(3 + $urandom % 2);
			else
				iss.alu_op = alu_op_t'(10 + $urandom % 6);
			a = pick_operand(iss.operand1_sel, iss);
			b = pick_operand(iss.operand2_sel, iss);
			if (iss.inst_class == CLASS_ARITH)
				exp = expected(iss, 1, alu_ref(iss.alu_op, a, b), iss.pc + 4);
			else
				exp = expected(iss, 1, word_t'(compare_ref(iss.alu_op, a, b)), iss.pc + 4);
			execute_one(iss, exp, 1, 1);
		end
		report_group("alu_compare", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int i = 0; i < N_JUMP_BRANCH / 2; i++) begin
			iss = new_issue(CLASS_JUMP);
			iss.operand1_sel = ($urandom % 2) ? OPSEL_PC : OPSEL_RS1;
			a = pick_operand(iss.operand1_sel, iss);
			exp = expected(iss, 1, iss.pc + 4, a + iss.imm);
			execute_one(iss, exp, 1, 1);
			iss = new_issue(CLASS_BRANCH);
			iss.operand2_sel = OPSEL_RS2;
			iss.alu_op = alu_op_t'(10 + $urandom % 6);
			if ($urandom % 2)
				iss.rs2 = iss.rs1;
			exp = expected(iss, 0, '0,
				compare_ref(iss.alu_op, iss.rs1, iss.rs2) ? iss.pc + iss.imm : iss.pc + 4);
			execute_one(iss, exp, 1, 0);
		end
		report_group("jump_branch", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int op = 0; op < 4; op++) begin
			for (int i = 0; i < N_MUL / 4; i++) begin
				iss = new_issue(CLASS_COMPLEX);
				iss.cplx_op = cplx_op_t'(op);
				if (i < 5) begin
					iss.rs1 = CORNERS[i];
					iss.rs2 = CORNERS[$urandom % 5];
				end
				exp = expected(iss, 1, mul_ref(iss.cplx_op, iss.rs1, iss.rs2), iss.pc + 4);
				execute_one(iss, exp, 3, 1);
			end
		end
		report_group("multiply", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int op = 4; op < 8; op++) begin
			for (int i = 0; i < N_DIV / 4; i++) begin
				iss = new_issue(CLASS_COMPLEX);
				iss.cplx_op = cplx_op_t'(op);
				if (i == 0) begin
					iss.rs2 = '0;
				end else if (i == 1) begin
					iss.rs1 = 32'h8000_0000;
					iss.rs2 = '1;
				end else if (i % 2) begin
					iss.rs2 = word_t'($urandom % 64) + 1;
				end
				exp = expected(iss, 1, div_ref(iss.cplx_op, iss.rs1, iss.rs2), iss.pc + 4);
				execute_one(iss, exp, MAX_LATENCY, 1);
			end
		end
		report_group("divide", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int i = 0; i < N_MEM / 2; i++) begin
			idx = $urandom % 256;
			width = mem_width_t'($urandom % 3);
			off = (width == MEM_BYTE) ? $urandom % 4
				: (width == MEM_HALF) ? 2 * ($urandom % 2) : 0;
			lanes = (width == MEM_BYTE) ? 4'b0001 << off
				: (width == MEM_HALF) ? 4'b0011 << off : 4'b1111;
			a = word_t'(idx * 4 + off);
			iss = new_issue(CLASS_STORE);
			iss.imm = word_t'($urandom % 128) - 64;
			iss.rs1 = a - iss.imm;
			iss.mem_width = width;
			exp = expected(iss, 0, '0, iss.pc + 4);
			execute_one(iss, exp, 0, 0);
			check_bus_request(a, lanes);
			case (width)
				MEM_BYTE: shadow[idx][8*off +: 8] = iss.rs2[7:0];
				MEM_HALF: shadow[idx][8*off +: 16] = iss.rs2[15:0];
				default: shadow[idx] = iss.rs2;
			endcase
			check(mem[idx] == shadow[idx], 1, $sformatf("memory word %0d is %h, expected %h",
				idx, mem[idx], shadow[idx]));
			iss.inst_class = CLASS_LOAD;
			iss.mem_signed = 1'($urandom % 2);
			iss.rd = reg_addr_t'($urandom);
			exp = expected(iss, 1, load_ref(a, width, iss.mem_signed), iss.pc + 4);
			execute_one(iss, exp, 0, 1);
			check_bus_request(a, lanes);
		end
		report_group("load_store", c0, e0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
